// ==== all.f ====
+incdir+design
design/acc_hive_pkg.sv
design/acc_req_arbiter.sv
design/shared_muldiv.sv
design/acc_resp_router.sv
design/acc_hive.sv
test/acc_hive_checker.sv
test/acc_hive_assert.sv
test/tb_acc_hive.sv

// ==== run.sh ====
#!/bin/sh
# Build the hive testbench with Verilator, run it and look for the pass message
verilator --binary --timing --assert -f all.f --top-module tb_acc_hive \
  && ./obj_dir/Vtb_acc_hive | tee /dev/stderr | grep -q "Verification passed" \
  && echo "Run passed" \
  || { echo "Run failed"; exit 1; }

// ==== test/tb_acc_hive.sv ====
// Testbench for the accelerator hive driving table requests from four cores under back-pressure

`include "acc_hive_defines.svh"

module tb_acc_hive
  import acc_hive_pkg::*;
();

  localparam int CLK_PERIOD     = 8;
  localparam int NUM_ENTRIES    = 16;
  localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 45 + 100;

  logic                           clk_i = 1'b0;
  logic                           rst_i;
  acc_req_t [`ACC_CORE_COUNT-1:0] core_req_i;
  logic     [`ACC_CORE_COUNT-1:0] core_qvalid_i;
  logic     [`ACC_CORE_COUNT-1:0] core_qready_o;
  acc_rsp_t [`ACC_CORE_COUNT-1:0] core_rsp_o;
  logic     [`ACC_CORE_COUNT-1:0] core_pvalid_o;
  logic     [`ACC_CORE_COUNT-1:0] core_pready_i;

  int     mismatch_count;
  int     other_count;
  int     resp_count;
  int     cycle_count;
  integer seed = 19676;

  // Stimulus table, one row per request
  string     t_name  [NUM_ENTRIES];
  logic      t_group [NUM_ENTRIES];
  core_idx_t t_core  [NUM_ENTRIES];
  core_id_t  t_id    [NUM_ENTRIES];
  op_t       t_op    [NUM_ENTRIES];
  data_t     t_arga  [NUM_ENTRIES];
  data_t     t_argb  [NUM_ENTRIES];

  acc_hive DUT (.*);

  acc_hive_checker u_checker (
    .clk_i            ( clk_i          ),
    .rst_i            ( rst_i          ),
    .core_qvalid_i    ( core_qvalid_i  ),
    .core_qready_i    ( core_qready_o  ),
    .core_rsp_i       ( core_rsp_o     ),
    .core_pvalid_i    ( core_pvalid_o  ),
    .core_pready_i    ( core_pready_i  ),
    .mismatch_count_o ( mismatch_count ),
    .other_count_o    ( other_count    ),
    .resp_count_o     ( resp_count     )
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // --------------------
  // Stimulus table
  // --------------------
  task automatic set_entry(input int i, input string name, input logic group, input core_idx_t core,
                           input core_id_t id, input op_t op, input data_t arga, input data_t argb);
    t_name[i]  = name;
    t_group[i] = group;
    t_core[i]  = core;
    t_id[i]    = id;
    t_op[i]    = op;
    t_arga[i]  = arga;
    t_argb[i]  = argb;
  endtask

  // A row with the group flag starts four rows for cores 0 to 3 launched together
  task automatic load_table();
    set_entry(0, "mul_small", 1'b0, 2'd0, 5'd1, OP_MUL, 32'd6, 32'd7);
    set_entry(1, "mulhu_ones", 1'b0, 2'd1, 5'd2, OP_MULHU, 32'hffffffff, 32'hffffffff);
    set_entry(2, "mul_ones", 1'b0, 2'd2, 5'd3, OP_MUL, 32'hffffffff, 32'hffffffff);
    set_entry(3, "divu_basic", 1'b0, 2'd3, 5'd4, OP_DIVU, 32'd1000, 32'd7);
    set_entry(4, "remu_zero", 1'b0, 2'd0, 5'd5, OP_REMU, 32'hdeadbeef, 32'd0);
    set_entry(5, "divu_zero", 1'b0, 2'd1, 5'd6, OP_DIVU, 32'hdeadbeef, 32'd0);
    set_entry(6, "illegal_4", 1'b0, 2'd2, 5'd7, 3'd4, 32'd9, 32'd9);
    // Core 2 granted last, so the group drains 3, 0, 1, 2
    set_entry(7, "grp_a_remu", 1'b1, 2'd0, 5'd7, OP_REMU, 32'd1000, 32'd7);
    set_entry(8, "grp_a_divu", 1'b0, 2'd1, 5'd7, OP_DIVU, 32'hffffffff, 32'd3);
    set_entry(9, "grp_a_mulhu", 1'b0, 2'd2, 5'd7, OP_MULHU, 32'h12345678, 32'h9abcdef0);
    set_entry(10, "grp_a_ill_7", 1'b0, 2'd3, 5'd7, 3'd7, 32'd1, 32'd2);
    set_entry(11, "rr_prime_c0", 1'b0, 2'd0, 5'd9, OP_MUL, 32'd3, 32'd5);
    // Core 0 granted last, so the group drains 1, 2, 3, 0
    set_entry(12, "grp_b_divu", 1'b1, 2'd0, 5'd31, OP_DIVU, 32'd1, 32'd1);
    set_entry(13, "grp_b_mul", 1'b0, 2'd1, 5'd31, OP_MUL, 32'd0, 32'hffffffff);
    set_entry(14, "grp_b_remu", 1'b0, 2'd2, 5'd31, OP_REMU, 32'hffffffff, 32'hfffffffe);
    set_entry(15, "grp_b_ill_5", 1'b0, 2'd3, 5'd31, 3'd5, 32'd4, 32'd4);
  endtask

  // Raise valid for a set of rows and hold each one until its core is taken
  task automatic issue_batch(input int first, input int count);
    logic [`ACC_CORE_COUNT-1:0] waiting;
    logic [`ACC_CORE_COUNT-1:0] taken;
    waiting = '0;
    @(negedge clk_i);
    for (int k = first; k < first + count; k++) begin
      core_req_i[t_core[k]]    = {t_id[k], t_op[k], t_arga[k], t_argb[k]};
      core_qvalid_i[t_core[k]] = 1'b1;
      waiting[t_core[k]]       = 1'b1;
    end
    while (waiting != '0) begin
      // Ready is settled well before the rising edge
      #(CLK_PERIOD / 4);
      taken = waiting & core_qready_o;
      @(negedge clk_i);
      core_qvalid_i = core_qvalid_i & ~taken;
      waiting       = waiting & ~taken;
    end
  endtask

  // --------------------
  // Response back-pressure
  // --------------------
  initial begin
    core_pready_i = '0;
    forever begin
      @(negedge clk_i);
      for (int c = 0; c < `ACC_CORE_COUNT; c++) begin
        core_pready_i[c] = !rst_i && (({$random(seed)} % 10) < 7);
      end
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout after %0d cycles: responses did not all arrive in time", cycle_count);
    $display("Verification failed");
    $finish;
  end

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    int i;
    rst_i         = 1'b1;
    core_qvalid_i = '0;
    core_req_i    = '0;
    load_table();
    for (int k = 0; k < NUM_ENTRIES; k++) begin
      u_checker.add_expect(t_name[k], t_core[k], t_id[k], t_op[k], t_arga[k], t_argb[k]);
    end
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    i = 0;
    while (i < NUM_ENTRIES) begin
      if (t_group[i]) begin
        issue_batch(i, `ACC_CORE_COUNT);
        i = i + `ACC_CORE_COUNT;
      end else begin
        issue_batch(i, 1);
        i = i + 1;
      end
    end
    while (resp_count < NUM_ENTRIES) @(negedge clk_i);
    // Spare cycles so a stray extra response still gets seen
    repeat (8) @(negedge clk_i);
    $display("Error counts: %0d mismatches, %0d other errors", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== test/acc_hive_assert.sv ====
// Protocol assertions on the response channels of the accelerator hive

`include "acc_hive_defines.svh"

module acc_hive_assert
  import acc_hive_pkg::*;
(
  input logic                           clk_i,
  input logic                           rst_i,
  input acc_rsp_t [`ACC_CORE_COUNT-1:0] core_rsp_i,
  input logic     [`ACC_CORE_COUNT-1:0] core_pvalid_i,
  input logic     [`ACC_CORE_COUNT-1:0] core_pready_i
);

  // Stalled response keeps its valid and payload
  rsp_held_a: assert property (@(posedge clk_i) disable iff (rst_i)
    (|(core_pvalid_i & ~core_pready_i)) |=> $stable(core_pvalid_i) && $stable(core_rsp_i))
    else $error("Response changed while its core held ready low");

  rsp_reset_a: assert property (@(posedge clk_i) rst_i |=> core_pvalid_i == '0)
    else $error("Core response valid high right after reset");

  // Single unit, so one core at a time
  rsp_onehot_a: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(core_pvalid_i))
    else $error("More than one core response valid at once");

endmodule

bind acc_hive acc_hive_assert u_acc_hive_assert (
  .clk_i         ( clk_i         ),
  .rst_i         ( rst_i         ),
  .core_rsp_i    ( core_rsp_o    ),
  .core_pvalid_i ( core_pvalid_o ),
  .core_pready_i ( core_pready_i )
);

// ==== test/acc_hive_checker.sv ====
// Scoreboard that predicts each core's responses and the round-robin grant order of the hive

`include "acc_hive_defines.svh"

module acc_hive_checker
  import acc_hive_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic     [`ACC_CORE_COUNT-1:0] core_qvalid_i,
  input  logic     [`ACC_CORE_COUNT-1:0] core_qready_i,
  input  acc_rsp_t [`ACC_CORE_COUNT-1:0] core_rsp_i,
  input  logic     [`ACC_CORE_COUNT-1:0] core_pvalid_i,
  input  logic     [`ACC_CORE_COUNT-1:0] core_pready_i,
  output int                             mismatch_count_o,
  output int                             other_count_o,
  output int                             resp_count_o
);

  string     exp_name [$];
  core_id_t  exp_id   [$];
  logic      exp_error[$];
  data_t     exp_data [$];
  // Per core, indices into the lists above, oldest first
  int        pend_q   [`ACC_CORE_COUNT][$];
  // Granted cores still waiting for their response
  core_idx_t grant_q  [$];
  core_idx_t rr_start;
  int        mismatch_count = 0;
  int        other_count    = 0;
  int        resp_count     = 0;

  assign mismatch_count_o = mismatch_count;
  assign other_count_o    = other_count;
  assign resp_count_o     = resp_count;

  // --------------------
  // Reference model
  // --------------------
  task automatic add_expect(input string name, input core_idx_t core, input core_id_t id,
                            input op_t op, input data_t arga, input data_t argb);
    logic [2*`ACC_DATA_WIDTH-1:0] prod;
    logic                         error;
    data_t                        data;
    prod  = {{`ACC_DATA_WIDTH{1'b0}}, arga} * {{`ACC_DATA_WIDTH{1'b0}}, argb};
    error = 1'b0;
    data  = '0;
    case (op)
      OP_MUL:   data = prod[`ACC_DATA_WIDTH-1:0];
      OP_MULHU: data = prod[2*`ACC_DATA_WIDTH-1:`ACC_DATA_WIDTH];
      // Zero divisor gives all ones and the dividend back
      OP_DIVU:  data = (argb == '0) ? '1 : arga / argb;
      OP_REMU:  data = (argb == '0) ? arga : arga % argb;
      default:  error = 1'b1;
    endcase
    exp_name.push_back(name);
    exp_id.push_back(id);
    exp_error.push_back(error);
    exp_data.push_back(data);
    pend_q[core].push_back(exp_name.size() - 1);
  endtask

  task automatic check_response(input core_idx_t c);
    int idx;
    resp_count++;
    if (grant_q.size() == 0 || grant_q[0] != c) begin
      other_count++;
      $display("Response on core %0d arrived out of grant order", c);
    end
    if (grant_q.size() != 0) begin
      grant_q.delete(0);
    end
    if (pend_q[c].size() == 0) begin
      other_count++;
      $display("Response on core %0d arrived with no request outstanding", c);
    end else begin
      idx = pend_q[c].pop_front();
      if (core_rsp_i[c].id !== exp_id[idx]) begin
        mismatch_count++;
        $display("MISMATCH %s id: expected %0d actual %0d", exp_name[idx], exp_id[idx],
                 core_rsp_i[c].id);
      end
      if (core_rsp_i[c].error !== exp_error[idx]) begin
        mismatch_count++;
        $display("MISMATCH %s error: expected %0b actual %0b", exp_name[idx], exp_error[idx],
                 core_rsp_i[c].error);
      end
      if (core_rsp_i[c].data !== exp_data[idx]) begin
        mismatch_count++;
        $display("MISMATCH %s data: expected %h actual %h", exp_name[idx], exp_data[idx],
                 core_rsp_i[c].data);
      end
    end
  endtask

  // First valid core at or after the round-robin start wins
  task automatic check_grant();
    core_idx_t probe;
    core_idx_t cand;
    logic      found;
    found = 1'b0;
    cand  = rr_start;
    for (int i = 0; i < `ACC_CORE_COUNT; i++) begin
      probe = rr_start + core_idx_t'(i);
      if (!found && core_qvalid_i[probe]) begin
        found = 1'b1;
        cand  = probe;
      end
    end
    if ((core_qvalid_i & core_qready_i) != (`ACC_CORE_COUNT'(1) << cand)) begin
      other_count++;
      $display("Grant went to the wrong core: expected core %0d, ready was %b", cand,
               core_qready_i);
    end
    grant_q.push_back(cand);
    rr_start = cand + core_idx_t'(1);
  endtask

  always @(posedge clk_i) begin
    if (rst_i) begin
      rr_start = '0;
    end else begin
      for (int c = 0; c < `ACC_CORE_COUNT; c++) begin
        if (core_pvalid_i[c] && core_pready_i[c]) begin
          check_response(core_idx_t'(c));
        end
      end
      if ((core_qvalid_i & core_qready_i) != '0) begin
        check_grant();
      end
    end
  end

endmodule

// ==== design/acc_hive.sv ====
// Accelerator hive top joining the request arbiter, the shared unit and the response router

`include "acc_hive_defines.svh"

module acc_hive
  import acc_hive_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  acc_req_t [`ACC_CORE_COUNT-1:0] core_req_i,
  input  logic     [`ACC_CORE_COUNT-1:0] core_qvalid_i,
  output logic     [`ACC_CORE_COUNT-1:0] core_qready_o,
  output acc_rsp_t [`ACC_CORE_COUNT-1:0] core_rsp_o,
  output logic     [`ACC_CORE_COUNT-1:0] core_pvalid_o,
  input  logic     [`ACC_CORE_COUNT-1:0] core_pready_i
);

  // Arbiter to unit
  acc_ext_req_t unit_req;
  logic         unit_qvalid;
  logic         unit_qready;

  // Unit to router
  acc_ext_rsp_t unit_rsp;
  logic         unit_pvalid;
  logic         unit_pready;

  // --------------------
  // Input side
  // --------------------
  acc_req_arbiter i_acc_req_arbiter (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .core_req_i    ( core_req_i    ),
    .core_qvalid_i ( core_qvalid_i ),
    .core_qready_o ( core_qready_o ),
    .unit_req_o    ( unit_req      ),
    .unit_qvalid_o ( unit_qvalid   ),
    .unit_qready_i ( unit_qready   )
  );

  // --------------------
  // Shared unit
  // --------------------
  shared_muldiv i_shared_muldiv (
    .clk_i    ( clk_i       ),
    .rst_i    ( rst_i       ),
    .req_i    ( unit_req    ),
    .qvalid_i ( unit_qvalid ),
    .qready_o ( unit_qready ),
    .rsp_o    ( unit_rsp    ),
    .pvalid_o ( unit_pvalid ),
    .pready_i ( unit_pready )
  );

  // --------------------
  // Output side
  // --------------------
  acc_resp_router i_acc_resp_router (
    .rsp_i         ( unit_rsp      ),
    .pvalid_i      ( unit_pvalid   ),
    .pready_o      ( unit_pready   ),
    .core_rsp_o    ( core_rsp_o    ),
    .core_pvalid_o ( core_pvalid_o ),
    .core_pready_i ( core_pready_i )
  );

endmodule

// ==== design/acc_resp_router.sv ====
// Response router that returns each unit response to its core and removes the core index

`include "acc_hive_defines.svh"

module acc_resp_router
  import acc_hive_pkg::*;
(
  input  acc_ext_rsp_t                   rsp_i,
  input  logic                           pvalid_i,
  output logic                           pready_o,
  output acc_rsp_t [`ACC_CORE_COUNT-1:0] core_rsp_o,
  output logic     [`ACC_CORE_COUNT-1:0] core_pvalid_o,
  input  logic     [`ACC_CORE_COUNT-1:0] core_pready_i
);

  core_idx_t sel;

  // Core index sits above the original id
  assign sel = rsp_i.id[`ACC_CORE_IDX_WIDTH+`ACC_ID_WIDTH-1:`ACC_ID_WIDTH];

  // --------------------
  // Valid steering
  // --------------------
  always_comb begin
    for (int i = 0; i < `ACC_CORE_COUNT; i++) begin
      core_pvalid_o[i] = pvalid_i && (sel == core_idx_t'(i));
    end
  end

  // Only the addressed core may accept
  assign pready_o = core_pready_i[sel];

  // --------------------
  // Payload
  // --------------------

  // Every core sees the same payload with its own id restored
  always_comb begin
    for (int i = 0; i < `ACC_CORE_COUNT; i++) begin
      core_rsp_o[i].id    = rsp_i.id[`ACC_ID_WIDTH-1:0];
      core_rsp_o[i].error = rsp_i.error;
      core_rsp_o[i].data  = rsp_i.data;
    end
  end

endmodule

// ==== design/shared_muldiv.sv ====
// Shared multiply/divide unit serving one request at a time with iterative division

`include "acc_hive_defines.svh"

module shared_muldiv
  import acc_hive_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_i,
  input  acc_ext_req_t req_i,
  input  logic         qvalid_i,
  output logic         qready_o,
  output acc_ext_rsp_t rsp_o,
  output logic         pvalid_o,
  input  logic         pready_i
);

  typedef logic [2*`ACC_DATA_WIDTH-1:0]     product_t;
  typedef logic [$clog2(`ACC_DATA_WIDTH):0] step_t;

  muldiv_state_e state_q, state_d;
  step_t         step_q;

  acc_ext_rsp_t  rsp_q;
  op_t           op_q;
  data_t         divisor_q;
  // Partial remainder
  data_t         rem_q;
  // Dividend shifts out on top while quotient bits enter below
  data_t         quo_q;

  logic          accept;
  logic          div_op;
  logic          step_done;
  product_t      product;
  logic [`ACC_DATA_WIDTH:0] rem_shift;
  logic [`ACC_DATA_WIDTH:0] rem_diff;

  // --------------------
  // Handshake and decode
  // --------------------
  assign qready_o  = (state_q == MD_IDLE);
  assign accept    = qvalid_i && qready_o;
  assign div_op    = (req_i.op == OP_DIVU) || (req_i.op == OP_REMU);
  assign step_done = (step_q == step_t'(`ACC_DATA_WIDTH));

  // Full unsigned product straight from the request
  assign product = product_t'(req_i.arga) * product_t'(req_i.argb);

  // One restoring step.
  // A borrow out of the top bit means the divisor did not fit
  assign rem_shift = {rem_q, quo_q[`ACC_DATA_WIDTH-1]};
  assign rem_diff  = rem_shift - {1'b0, divisor_q};

  // --------------------
  // FSM
  // --------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      MD_IDLE: begin
        if (accept) begin
          state_d = div_op ? MD_DIV : MD_RESP;
        end
      end
      MD_DIV: begin
        if (step_done) begin
          state_d = MD_RESP;
        end
      end
      MD_RESP: begin
        if (pready_i) begin
          state_d = MD_IDLE;
        end
      end
      default: state_d = MD_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= MD_IDLE;
      step_q  <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        step_q <= '0;
      end else if (state_q == MD_DIV && !step_done) begin
        step_q <= step_q + step_t'(1);
      end
    end
  end

  // --------------------
  // Datapath
  // --------------------
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_q.id    <= req_i.id;
      rsp_q.error <= 1'b0;
      op_q        <= req_i.op;
      divisor_q   <= req_i.argb;
      quo_q       <= req_i.arga;
      rem_q       <= '0;
      unique case (req_i.op)
        OP_MUL:   rsp_q.data <= product[`ACC_DATA_WIDTH-1:0];
        OP_MULHU: rsp_q.data <= product[2*`ACC_DATA_WIDTH-1:`ACC_DATA_WIDTH];
        // Filled in when the last step is done
        OP_DIVU,
        OP_REMU:  rsp_q.data <= '0;
        default: begin
          rsp_q.error <= 1'b1;
          rsp_q.data  <= '0;
        end
      endcase
    end else if (state_q == MD_DIV) begin
      if (step_done) begin
        rsp_q.data <= (op_q == OP_REMU) ? rem_q : quo_q;
      end else begin
        // Zero divisor never borrows, so the quotient
        // fills with ones and the remainder ends as arga
        quo_q <= {quo_q[`ACC_DATA_WIDTH-2:0], ~rem_diff[`ACC_DATA_WIDTH]};
        if (rem_diff[`ACC_DATA_WIDTH]) begin
          rem_q <= rem_shift[`ACC_DATA_WIDTH-1:0];
        end else begin
          rem_q <= rem_diff[`ACC_DATA_WIDTH-1:0];
        end
      end
    end
  end

  // Response held stable in MD_RESP until taken
  assign rsp_o    = rsp_q;
  assign pvalid_o = (state_q == MD_RESP);

endmodule

// ==== design/acc_req_arbiter.sv ====
// Round-robin arbiter that tags core requests with the core index and registers the winner

`include "acc_hive_defines.svh"

module acc_req_arbiter
  import acc_hive_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  acc_req_t [`ACC_CORE_COUNT-1:0]      core_req_i,
  input  logic     [`ACC_CORE_COUNT-1:0]      core_qvalid_i,
  output logic     [`ACC_CORE_COUNT-1:0]      core_qready_o,
  output acc_ext_req_t                        unit_req_o,
  output logic                                unit_qvalid_o,
  input  logic                                unit_qready_i
);

  // First core to look at in the next search
  core_idx_t    start_q;
  core_idx_t    grant_idx;
  logic         grant_valid;
  logic         slot_free;
  logic         accept;

  acc_ext_req_t slot_req_q;
  logic         slot_valid_q;

  // --------------------
  // Grant selection
  // --------------------

  // Walk the cores once, beginning at start_q. The index wraps with its width
  always_comb begin
    core_idx_t cand;
    cand        = start_q;
    grant_valid = 1'b0;
    grant_idx   = start_q;
    for (int i = 0; i < `ACC_CORE_COUNT; i++) begin
      cand = start_q + core_idx_t'(i);
      if (!grant_valid && core_qvalid_i[cand]) begin
        grant_valid = 1'b1;
        grant_idx   = cand;
      end
    end
  end

  // Slot can take a new entry when empty or drained this cycle
  assign slot_free = !slot_valid_q || unit_qready_i;
  assign accept    = grant_valid && slot_free;

  always_comb begin
    core_qready_o = '0;
    core_qready_o[grant_idx] = grant_valid && slot_free;
  end

  // --------------------
  // Registered slot
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      slot_valid_q <= 1'b0;
      start_q      <= '0;
    end else begin
      if (accept) begin
        slot_valid_q <= 1'b1;
        // Granted core drops to lowest priority
        start_q      <= grant_idx + core_idx_t'(1);
      end else if (unit_qready_i) begin
        slot_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      slot_req_q.id   <= {grant_idx, core_req_i[grant_idx].id};
      slot_req_q.op   <= core_req_i[grant_idx].op;
      slot_req_q.arga <= core_req_i[grant_idx].arga;
      slot_req_q.argb <= core_req_i[grant_idx].argb;
    end
  end

  assign unit_req_o    = slot_req_q;
  assign unit_qvalid_o = slot_valid_q;

endmodule

// ==== design/acc_hive_pkg.sv ====
// Shared vector types, operation codes and channel structs of the accelerator hive

`include "acc_hive_defines.svh"

package acc_hive_pkg;

  // --------------------
  // Vector types
  // --------------------
  typedef logic [`ACC_DATA_WIDTH-1:0]     data_t;
  typedef logic [`ACC_ID_WIDTH-1:0]       core_id_t;
  typedef logic [`ACC_CORE_IDX_WIDTH-1:0] core_idx_t;
  // Core index on top, core id below
  typedef logic [`ACC_CORE_IDX_WIDTH+`ACC_ID_WIDTH-1:0] ext_id_t;
  typedef logic [2:0] op_t;

  // --------------------
  // Operation codes
  // --------------------
  localparam op_t OP_MUL   = 3'd0;
  localparam op_t OP_MULHU = 3'd1;
  localparam op_t OP_DIVU  = 3'd2;
  localparam op_t OP_REMU  = 3'd3;
  // Codes 4 to 7 come back with the error flag set

  // --------------------
  // Channel payloads
  // --------------------
  typedef struct packed {
    core_id_t id;
    op_t      op;
    data_t    arga;
    data_t    argb;
  } acc_req_t;

  typedef struct packed {
    ext_id_t id;
    op_t     op;
    data_t   arga;
    data_t   argb;
  } acc_ext_req_t;

  typedef struct packed {
    core_id_t id;
    logic     error;
    data_t    data;
  } acc_rsp_t;

  typedef struct packed {
    ext_id_t id;
    logic    error;
    data_t   data;
  } acc_ext_rsp_t;

  // Shared unit FSM
  typedef enum logic [1:0] {
    MD_IDLE,
    MD_DIV,
    MD_RESP
  } muldiv_state_e;

endpackage

// ==== design/acc_hive_defines.svh ====
// Size constants shared by every block of the accelerator hive

`ifndef ACC_HIVE_DEFINES_SVH
`define ACC_HIVE_DEFINES_SVH

// --------------------
// Cluster size
// --------------------

// Cores sharing the unit
`define ACC_CORE_COUNT 4
// Enough bits to name any core
`define ACC_CORE_IDX_WIDTH 2

// --------------------
// Payload widths
// --------------------

// Transaction id as issued by a core
`define ACC_ID_WIDTH 5
// Operands and results
`define ACC_DATA_WIDTH 32

`endif
